/* sources.f */
hdl/bp_mem_pkg.sv
hdl/bp_lce_cce_pkg.sv
hdl/bp_two_fifo.sv
hdl/bp_io_cce.sv
hdl/bp_io_scratch.sv
hdl/bp_io_subsys.sv
tb/tb_clock_gen.sv
tb/tb_io_subsys.sv

/* tb/tb_io_subsys.sv */
`timescale 1ns/1ns

module tb_io_subsys
  import bp_mem_pkg::*;
  import bp_lce_cce_pkg::*;
  ();

  localparam int mem_els_lp      = 16;
  localparam int req_total_lp    = 78;
  localparam int limit_cycles_lp = req_total_lp * 20 + 500;

  logic                       clk;
  logic                       reset;
  logic [cce_id_width_gp-1:0] cce_id;
  lce_req_s                   req;
  logic                       req_v;
  logic                       req_yumi;
  lce_cmd_s                   cmd;
  logic                       cmd_v;
  logic                       cmd_ready;

  logic [7:0] ref_mem [mem_els_lp*8];
  lce_cmd_s   exp_q [$];
  lce_cmd_s   got_q [$];
  string      test_name;
  int         errors = 0;
  int         checks = 0;
  int         tests = 0;
  int         test_errors_start;
  bit         rand_ready = 1'b0;
  integer     seed = 32'h2415546a;

  tb_clock_gen clock_gen (.clk_o(clk), .reset_o(reset));

  bp_io_subsys #(.mem_els_p(mem_els_lp)) uut
  (
    .clk_i           (clk),
    .reset_i         (reset),
    .cce_id_i        (cce_id),
    .lce_req_i       (req),
    .lce_req_v_i     (req_v),
    .lce_req_yumi_o  (req_yumi),
    .lce_cmd_o       (cmd),
    .lce_cmd_v_o     (cmd_v),
    .lce_cmd_ready_i (cmd_ready)
  );

  // a transfer at the next edge is already visible half a cycle ahead.
  always @(negedge clk)
  begin
    if (!reset && cmd_v && cmd_ready)
      got_q.push_back(cmd);
  end

  task automatic check_cmd(input lce_cmd_s exp_cmd, input lce_cmd_s act_cmd);
    checks++;
    if (act_cmd !== exp_cmd)
    begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", test_name, exp_cmd, act_cmd);
    end
  endtask

  task automatic check_bit(input string what, input logic exp_bit, input logic act_bit);
    checks++;
    if (act_bit !== exp_bit)
    begin
      errors++;
      $display("FAIL %s (%s): expected %b, actual %b", test_name, what, exp_bit, act_bit);
    end
  endtask

  task automatic start_test(input string name);
    test_name         = name;
    test_errors_start = errors;
    tests++;
  endtask

  task automatic finish_test();
    $display("test %s: %0d errors", test_name, errors - test_errors_start);
  endtask

  function automatic lce_req_s make_req(input logic wr, input logic [1:0] src,
                                        input logic [15:0] addr, input logic [1:0] size,
                                        input logic [63:0] data);
    lce_req_s r;
    r.msg_type = wr ? e_lce_req_uc_wr : e_lce_req_uc_rd;
    r.src_id   = src;
    r.addr     = addr;
    r.size     = size_e'(size);
    r.data     = data;
    return r;
  endfunction

  // byte model of the scratch device in acceptance order.
  function automatic lce_cmd_s model_apply(input lce_req_s r);
    lce_cmd_s c;
    int       idx;
    int       nbytes;
    int       off;
    idx    = int'(r.addr >> 3) % mem_els_lp;
    nbytes = 1 << int'(r.size);
    off    = int'(r.addr[2:0]) & ~(nbytes - 1);
    c        = '0;
    c.dst_id = r.src_id;
    c.addr   = r.addr;
    if (r.msg_type == e_lce_req_uc_wr)
    begin
      for (int b = 0; b < nbytes; b++)
        ref_mem[idx*8 + off + b] = r.data[8*b +: 8];
      c.msg_type = e_lce_cmd_uc_st_done;
      c.src_id   = cce_id;
    end
    else
    begin
      for (int b = 0; b < nbytes; b++)
        c.data[8*b +: 8] = ref_mem[idx*8 + off + b];
      c.msg_type = e_lce_cmd_uc_data;
      c.size     = r.size;
    end
    return c;
  endfunction

  // one offer cycle that starts and ends 2 ns after an edge.
  task automatic offer_cycle(input lce_req_s r, output bit taken);
    req   = r;
    req_v = 1'b1;
    if (rand_ready)
      cmd_ready = 1'($random(seed));
    @(negedge clk);
    taken = req_yumi;
    if (taken)
      exp_q.push_back(model_apply(r));
    @(posedge clk);
    #2;
    req_v = 1'b0;
  endtask

  task automatic send_req(input lce_req_s r);
    bit taken;
    int waited;
    taken  = 1'b0;
    waited = 0;
    while (!taken && waited < 100)
    begin
      offer_cycle(r, taken);
      waited++;
    end
    if (!taken)
    begin
      errors++;
      $display("error in %s: a request was never accepted", test_name);
    end
  endtask

  task automatic drain_cmds();
    int waited;
    waited = 0;
    while (got_q.size() < exp_q.size() && waited < 200)
    begin
      if (rand_ready)
        cmd_ready = 1'($random(seed));
      @(posedge clk);
      #2;
      waited++;
    end
    cmd_ready = 1'b1;
    if (got_q.size() < exp_q.size())
    begin
      errors++;
      $display("error in %s: only %0d of %0d commands arrived", test_name,
               got_q.size(), exp_q.size());
    end
    while (exp_q.size() > 0 && got_q.size() > 0)
      check_cmd(exp_q.pop_front(), got_q.pop_front());
    if (got_q.size() > 0)
    begin
      errors++;
      $display("error in %s: %0d unexpected commands arrived", test_name, got_q.size());
    end
    exp_q.delete();
    got_q.delete();
  endtask

  task automatic test_reset();
    start_test("reset");
    repeat (3)
    begin
      @(negedge clk);
      check_bit("lce_cmd_v_o", 1'b0, cmd_v);
      check_bit("lce_req_yumi_o", 1'b0, req_yumi);
    end
    @(posedge clk);
    #2;
    finish_test();
  endtask

  // every word gets a known value before any read.
  task automatic test_preload();
    logic [15:0] a;
    start_test("preload");
    for (int i = 0; i < mem_els_lp; i++)
    begin
      a = 16'(i * 8);
      send_req(make_req(1'b1, 2'(i), a, e_size_8, {a, ~a, a ^ 16'h5a5a, a + 16'h1234}));
    end
    drain_cmds();
    finish_test();
  endtask

  task automatic test_full_word();
    start_test("full_word");
    send_req(make_req(1'b1, 2'd2, 16'h0078, e_size_8, 64'h0123_4567_89ab_cdef));
    send_req(make_req(1'b0, 2'd1, 16'h0078, e_size_8, 64'h0));
    drain_cmds();
    finish_test();
  endtask

  task automatic test_merge();
    start_test("merge");
    send_req(make_req(1'b1, 2'd0, 16'h0041, e_size_1, 64'hdead_beef_0000_00ab));
    send_req(make_req(1'b1, 2'd1, 16'h0043, e_size_2, 64'hdead_beef_0000_cdef));
    send_req(make_req(1'b1, 2'd2, 16'h0046, e_size_4, 64'hdead_beef_1234_5678));
    send_req(make_req(1'b1, 2'd3, 16'h0040, e_size_1, 64'hffff_ffff_ffff_ff99));
    send_req(make_req(1'b1, 2'd0, 16'h0047, e_size_2, 64'h5555_5555_5555_7766));
    send_req(make_req(1'b0, 2'd1, 16'h0040, e_size_8, 64'h0));
    drain_cmds();
    finish_test();
  endtask

  task automatic test_sized_reads();
    start_test("sized_reads");
    send_req(make_req(1'b0, 2'd0, 16'h0013, e_size_1, 64'h0));
    send_req(make_req(1'b0, 2'd1, 16'h0015, e_size_2, 64'h0));
    send_req(make_req(1'b0, 2'd2, 16'h0016, e_size_4, 64'h0));
    send_req(make_req(1'b0, 2'd3, 16'h0027, e_size_1, 64'h0));
    send_req(make_req(1'b0, 2'd0, 16'h0020, e_size_2, 64'h0));
    send_req(make_req(1'b0, 2'd1, 16'h002b, e_size_4, 64'h0));
    drain_cmds();
    finish_test();
  endtask

  task automatic test_backpressure();
    lce_req_s reqs [8];
    bit       taken;
    int       accepted;
    start_test("backpressure");
    accepted = 0;
    for (int i = 0; i < 8; i++)
      reqs[i] = make_req(1'(i), 2'(i), 16'(8 * i + 256), e_size_8, {32'(i), 32'hfeed_0000});
    cmd_ready = 1'b0;
    for (int c = 0; c < 12; c++)
    begin
      offer_cycle(reqs[accepted], taken);
      if (accepted >= 5)
        check_bit("lce_req_yumi_o after five", 1'b0, taken);
      if (taken)
        accepted++;
    end
    // two in the output queue, one in the device, two in the command queue.
    check_bit("five requests held", 1'b1, accepted == 5);
    cmd_ready = 1'b1;
    while (accepted < 8)
    begin
      send_req(reqs[accepted]);
      accepted++;
    end
    drain_cmds();
    finish_test();
  endtask

  task automatic test_random();
    start_test("random");
    rand_ready = 1'b1;
    for (int i = 0; i < 40; i++)
      send_req(make_req(1'($random(seed)), 2'($random(seed)), 16'($random(seed)),
                        2'($random(seed)), {$random(seed), $random(seed)}));
    drain_cmds();
    rand_ready = 1'b0;
    cmd_ready  = 1'b1;
    finish_test();
  endtask

  initial
  begin
    #(limit_cycles_lp * 40);
    $display("timeout: the tests did not finish within %0d cycles", limit_cycles_lp);
    $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    cce_id    = 2'd3;
    req       = '0;
    req_v     = 1'b0;
    cmd_ready = 1'b1;
    @(negedge reset);
    @(posedge clk);
    #2;
    test_reset();
    test_preload();
    test_full_word();
    test_merge();
    test_sized_reads();
    test_backpressure();
    test_random();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen
  #(parameter int period_p       = 40,
    parameter int reset_cycles_p = 10)
  (
    output logic clk_o,
    output logic reset_o
  );

  initial
  begin
    clk_o   = 1'b0;
    reset_o = 1'b1;
    repeat (reset_cycles_p) @(posedge clk_o);
    #2 reset_o = 1'b0;
  end

  always #(period_p / 2) clk_o = ~clk_o;

endmodule

/* hdl/bp_io_subsys.sv */
`timescale 1ns/1ns

module bp_io_subsys
  import bp_mem_pkg::*;
  import bp_lce_cce_pkg::*;
  #(parameter int mem_els_p = 16)
  (
    input  logic                       clk_i,
    input  logic                       reset_i,

    input  logic [cce_id_width_gp-1:0] cce_id_i,

    input  lce_req_s                   lce_req_i,
    input  logic                       lce_req_v_i,
    output logic                       lce_req_yumi_o,

    output lce_cmd_s                   lce_cmd_o,
    output logic                       lce_cmd_v_o,
    input  logic                       lce_cmd_ready_i
  );

  mem_msg_s mem_cmd;
  logic     mem_cmd_v;
  logic     mem_cmd_ready;

  mem_msg_s dev_cmd;
  logic     dev_cmd_v;
  logic     dev_cmd_ready;
  logic     dev_cmd_yumi;

  mem_msg_s mem_resp;
  logic     mem_resp_v;
  logic     mem_resp_yumi;

  lce_cmd_s lce_cmd;
  logic     lce_cmd_v;
  logic     lce_cmd_ready;
  logic     out_yumi;

  // queue heads leave on a valid and ready pair.
  assign dev_cmd_yumi = dev_cmd_v & dev_cmd_ready;
  assign out_yumi     = lce_cmd_v_o & lce_cmd_ready_i;

  bp_io_cce cce
  (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cce_id_i        (cce_id_i),
    .lce_req_i       (lce_req_i),
    .lce_req_v_i     (lce_req_v_i),
    .lce_req_yumi_o  (lce_req_yumi_o),
    .mem_cmd_o       (mem_cmd),
    .mem_cmd_v_o     (mem_cmd_v),
    .mem_cmd_ready_i (mem_cmd_ready),
    .mem_resp_i      (mem_resp),
    .mem_resp_v_i    (mem_resp_v),
    .mem_resp_yumi_o (mem_resp_yumi),
    .lce_cmd_o       (lce_cmd),
    .lce_cmd_v_o     (lce_cmd_v),
    .lce_cmd_ready_i (lce_cmd_ready)
  );

  bp_two_fifo #(.payload_t(mem_msg_s)) cmd_fifo
  (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (mem_cmd),
    .v_i     (mem_cmd_v),
    .ready_o (mem_cmd_ready),
    .data_o  (dev_cmd),
    .v_o     (dev_cmd_v),
    .yumi_i  (dev_cmd_yumi)
  );

  bp_io_scratch #(.mem_els_p(mem_els_p)) scratch
  (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .mem_cmd_i       (dev_cmd),
    .mem_cmd_v_i     (dev_cmd_v),
    .mem_cmd_ready_o (dev_cmd_ready),
    .mem_resp_o      (mem_resp),
    .mem_resp_v_o    (mem_resp_v),
    .mem_resp_yumi_i (mem_resp_yumi)
  );

  bp_two_fifo #(.payload_t(lce_cmd_s)) out_fifo
  (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (lce_cmd),
    .v_i     (lce_cmd_v),
    .ready_o (lce_cmd_ready),
    .data_o  (lce_cmd_o),
    .v_o     (lce_cmd_v_o),
    .yumi_i  (out_yumi)
  );

endmodule

/* hdl/bp_io_scratch.sv */
`timescale 1ns/1ns

module bp_io_scratch
  import bp_mem_pkg::*;
  #(parameter int mem_els_p = 16)
  (
    input  logic     clk_i,
    input  logic     reset_i,

    input  mem_msg_s mem_cmd_i,
    input  logic     mem_cmd_v_i,
    output logic     mem_cmd_ready_o,

    output mem_msg_s mem_resp_o,
    output logic     mem_resp_v_o,
    input  logic     mem_resp_yumi_i
  );

  localparam int idx_width_lp = $clog2(mem_els_p);
  localparam int bytes_lp     = data_width_gp / 8;

  logic [data_width_gp-1:0] mem_r [mem_els_p];

  mem_msg_s                 resp_r;
  logic                     resp_v_r;
  mem_msg_s                 resp_n;

  logic                     cmd_accept;
  logic [idx_width_lp-1:0]  word_idx;
  logic [2:0]               align_mask;
  logic [2:0]               byte_offset;
  logic [bytes_lp-1:0]      size_lanes;
  logic [bytes_lp-1:0]      lane_mask;
  logic [data_width_gp-1:0] size_bits;
  logic [data_width_gp-1:0] lane_bits;
  logic [data_width_gp-1:0] old_word;
  logic [data_width_gp-1:0] wr_shifted;
  logic [data_width_gp-1:0] wr_word;
  logic [data_width_gp-1:0] rd_data;

  // one response slot, refilled in the cycle it drains.
  assign mem_cmd_ready_o = ~resp_v_r | mem_resp_yumi_i;
  assign cmd_accept      = mem_cmd_v_i & mem_cmd_ready_o;

  assign mem_resp_o   = resp_r;
  assign mem_resp_v_o = resp_v_r;

  // word index wraps on the array size.
  assign word_idx = mem_cmd_i.addr[3 +: idx_width_lp];

  always_comb
  begin
    case (mem_cmd_i.size)
      e_size_1:
      begin
        size_lanes = 8'h01;
        align_mask = 3'b111;
      end
      e_size_2:
      begin
        size_lanes = 8'h03;
        align_mask = 3'b110;
      end
      e_size_4:
      begin
        size_lanes = 8'h0f;
        align_mask = 3'b100;
      end
      default:
      begin
        size_lanes = 8'hff;
        align_mask = 3'b000;
      end
    endcase
  end

  // offset rounded down to the access size.
  assign byte_offset = mem_cmd_i.addr[2:0] & align_mask;
  assign lane_mask   = size_lanes << byte_offset;

  always_comb
  begin
    for (int i = 0; i < bytes_lp; i++)
    begin
      size_bits[8*i +: 8] = {8{size_lanes[i]}};
      lane_bits[8*i +: 8] = {8{lane_mask[i]}};
    end
  end

  assign old_word   = mem_r[word_idx];
  assign wr_shifted = mem_cmd_i.data << {byte_offset, 3'b000};
  assign wr_word    = (old_word & ~lane_bits) | (wr_shifted & lane_bits);
  assign rd_data    = (old_word >> {byte_offset, 3'b000}) & size_bits;

  always_comb
  begin
    resp_n      = mem_cmd_i;
    resp_n.data = (mem_cmd_i.msg_type == e_mem_uc_rd) ? rd_data : '0;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_r <= 1'b0;
    else if (cmd_accept)
      resp_v_r <= 1'b1;
    else if (mem_resp_yumi_i)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_accept)
    begin
      resp_r <= resp_n;
      if (mem_cmd_i.msg_type == e_mem_uc_wr)
        mem_r[word_idx] <= wr_word;
    end
  end

endmodule

/* hdl/bp_io_cce.sv */
`timescale 1ns/1ns

module bp_io_cce
  import bp_mem_pkg::*;
  import bp_lce_cce_pkg::*;
  (
    input  logic                       clk_i,
    input  logic                       reset_i,

    input  logic [cce_id_width_gp-1:0] cce_id_i,

    input  lce_req_s                   lce_req_i,
    input  logic                       lce_req_v_i,
    output logic                       lce_req_yumi_o,

    output mem_msg_s                   mem_cmd_o,
    output logic                       mem_cmd_v_o,
    input  logic                       mem_cmd_ready_i,

    input  mem_msg_s                   mem_resp_i,
    input  logic                       mem_resp_v_i,
    output logic                       mem_resp_yumi_o,

    output lce_cmd_s                   lce_cmd_o,
    output logic                       lce_cmd_v_o,
    input  logic                       lce_cmd_ready_i
  );

  logic req_wr_not_rd;
  logic resp_wr_not_rd;

  // request path, taken only when the command queue has room.
  assign lce_req_yumi_o = lce_req_v_i & mem_cmd_ready_i;
  assign mem_cmd_v_o    = lce_req_yumi_o;

  assign req_wr_not_rd = (lce_req_i.msg_type == e_lce_req_uc_wr);

  always_comb
  begin
    mem_cmd_o                  = '0;
    mem_cmd_o.msg_type         = req_wr_not_rd ? e_mem_uc_wr : e_mem_uc_rd;
    mem_cmd_o.addr             = lce_req_i.addr;
    mem_cmd_o.size             = lce_req_i.size;
    mem_cmd_o.payload.lce_id   = lce_req_i.src_id;
    mem_cmd_o.payload.uncached = 1'b1;
    mem_cmd_o.data             = lce_req_i.data;
  end

  // response path, same pairing toward the output queue.
  assign mem_resp_yumi_o = mem_resp_v_i & lce_cmd_ready_i;
  assign lce_cmd_v_o     = mem_resp_yumi_o;

  assign resp_wr_not_rd = (mem_resp_i.msg_type == e_mem_uc_wr);

  always_comb
  begin
    lce_cmd_o        = '0;
    lce_cmd_o.dst_id = mem_resp_i.payload.lce_id;
    lce_cmd_o.addr   = mem_resp_i.addr;
    if (resp_wr_not_rd)
    begin
      // store done carries no size or data.
      lce_cmd_o.msg_type = e_lce_cmd_uc_st_done;
      lce_cmd_o.src_id   = cce_id_i;
    end
    else
    begin
      lce_cmd_o.msg_type = e_lce_cmd_uc_data;
      lce_cmd_o.size     = mem_resp_i.size;
      lce_cmd_o.data     = mem_resp_i.data;
    end
  end

endmodule

/* hdl/bp_two_fifo.sv */
`timescale 1ns/1ns

module bp_two_fifo
  #(parameter type payload_t = logic [7:0])
  (
    input  logic     clk_i,
    input  logic     reset_i,

    input  payload_t data_i,
    input  logic     v_i,
    output logic     ready_o,

    output payload_t data_o,
    output logic     v_o,
    input  logic     yumi_i
  );

  payload_t   mem_r [2];
  logic       rd_ptr_r;
  logic       wr_ptr_r;
  logic [1:0] count_r;

  logic       enq;
  logic       deq;

  // a full queue still takes a new item when the head leaves.
  assign ready_o = (count_r != 2'd2) | yumi_i;
  assign v_o     = (count_r != 2'd0);
  assign data_o  = mem_r[rd_ptr_r];

  assign enq = v_i & ready_o;
  assign deq = yumi_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rd_ptr_r <= 1'b0;
      wr_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= ~wr_ptr_r;
      if (deq)
        rd_ptr_r <= ~rd_ptr_r;
      if (enq & ~deq)
        count_r <= count_r + 2'd1;
      else if (deq & ~enq)
        count_r <= count_r - 2'd1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wr_ptr_r] <= data_i;
  end

endmodule

/* hdl/bp_lce_cce_pkg.sv */
package bp_lce_cce_pkg;

  import bp_mem_pkg::*;

  // lce id width follows the memory payload so the two always agree.
  localparam int lce_id_width_gp = mem_lce_id_width_gp;
  localparam int cce_id_width_gp = 2;

  // uncached request kinds from an LCE.
  typedef enum logic
  {
    e_lce_req_uc_rd = 1'b0,
    e_lce_req_uc_wr = 1'b1
  } lce_req_type_e;

  typedef struct packed
  {
    lce_req_type_e              msg_type;
    logic [lce_id_width_gp-1:0] src_id;
    logic [paddr_width_gp-1:0]  addr;
    size_e                      size;
    logic [data_width_gp-1:0]   data;
  } lce_req_s;

  // commands sent back to an LCE.
  typedef enum logic
  {
    e_lce_cmd_uc_data    = 1'b0,
    e_lce_cmd_uc_st_done = 1'b1
  } lce_cmd_type_e;

  // src_id names the CCE on a store done, zero on a data return.
  typedef struct packed
  {
    lce_cmd_type_e              msg_type;
    logic [lce_id_width_gp-1:0] dst_id;
    logic [cce_id_width_gp-1:0] src_id;
    logic [paddr_width_gp-1:0]  addr;
    size_e                      size;
    logic [data_width_gp-1:0]   data;
  } lce_cmd_s;

endpackage

/* hdl/bp_mem_pkg.sv */
package bp_mem_pkg;

  // physical address and data word widths.
  localparam int paddr_width_gp = 16;
  localparam int data_width_gp  = 64;

  // requester id carried in the memory payload.
  localparam int mem_lce_id_width_gp = 2;

  // access size, 1 << size bytes.
  typedef enum logic [1:0]
  {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10,
    e_size_8 = 2'b11
  } size_e;

  typedef enum logic
  {
    e_mem_uc_rd = 1'b0,
    e_mem_uc_wr = 1'b1
  } mem_msg_type_e;

  // returned untouched by the device.
  typedef struct packed
  {
    logic [mem_lce_id_width_gp-1:0] lce_id;
    logic                           uncached;
  } mem_payload_s;

  // used for both memory commands and memory responses.
  typedef struct packed
  {
    mem_msg_type_e              msg_type;
    logic [paddr_width_gp-1:0]  addr;
    size_e                      size;
    mem_payload_s               payload;
    logic [data_width_gp-1:0]   data;
  } mem_msg_s;

endpackage
